/* hdl/dds_pkg.sv */
package dds_pkg;

   //////////////////////////////////////////////////
   // sample and phase widths
   //////////////////////////////////////////////////
   localparam int SAMPLE_W = 12;

   typedef logic signed [SAMPLE_W-1:0] sample_t;

   localparam sample_t SAMPLE_MAX = 12'sh7FF;  // 2047
   localparam sample_t SAMPLE_MIN = 12'sh800;  // -2048

   localparam int PHASE_W = 32;
   localparam logic [PHASE_W-1:0] PHASE_INC = 32'd258;

   // quarter table, indexed by the 4 bits under the quadrant bits
   localparam int LUT_ADDR_W = 4;
   localparam logic [SAMPLE_W-1:0] SINE_QUARTER [2**LUT_ADDR_W] = '{
      12'd0,    12'd214,  12'd426,  12'd633,
      12'd833,  12'd1024, 12'd1203, 12'd1370,
      12'd1521, 12'd1656, 12'd1773, 12'd1870,
      12'd1947, 12'd2002, 12'd2036, 12'd2047
   };

   //////////////////////////////////////////////////
   // dividers and lfsr
   //////////////////////////////////////////////////
   localparam int SYMBOL_DIV   = 4096;  // clocks per symbol
   localparam int SYMBOL_CNT_W = 13;
   localparam int SAMPLE_DIV   = 64;    // clocks per sampling strobe
   localparam int SAMPLE_CNT_W = 7;

   localparam int LFSR_W = 5;
   localparam logic [LFSR_W-1:0] LFSR_SEED = 5'd1;

   //////////////////////////////////////////////////
   // keyboard codes and selections
   //////////////////////////////////////////////////
   typedef enum logic [7:0] {
      SC_1     = 8'h16,
      SC_2     = 8'h1E,
      SC_3     = 8'h26,
      SC_4     = 8'h25,
      SC_5     = 8'h2E,
      SC_6     = 8'h36,
      SC_7     = 8'h3D,
      SC_8     = 8'h3E,
      SC_BREAK = 8'hF0   // release prefix
   } scan_code_e;

   typedef enum logic [1:0] {SINE, COSINE, SAW, SQUARE} wave_sel_e;

   // CARRIER is the unmodulated cosine
   typedef enum logic [1:0] {ASK, BPSK, RAW, CARRIER} mod_sel_e;

endpackage

/* hdl/key_event_tracker.sv */
`timescale 1ns/1ns

module key_event_tracker
(
   input  logic                CLK_25MHZ,
   input  logic                reset_from_key,
   input  logic                key_valid,
   input  logic [7:0]          key_code,
   output dds_pkg::wave_sel_e  wave_sel,
   output dds_pkg::mod_sel_e   mod_sel
);

   typedef enum logic {IDLE, AFTER_BREAK} trk_state_e;

   trk_state_e state;

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         state    <= IDLE;
         wave_sel <= dds_pkg::SINE;
         mod_sel  <= dds_pkg::CARRIER;
      end
      else if (key_valid)
      begin
         case (state)
            IDLE:
            begin
               case (key_code)
                  dds_pkg::SC_BREAK: state <= AFTER_BREAK;
                  // waveform keys
                  dds_pkg::SC_1: wave_sel <= dds_pkg::SINE;
                  dds_pkg::SC_2: wave_sel <= dds_pkg::COSINE;
                  dds_pkg::SC_3: wave_sel <= dds_pkg::SAW;
                  dds_pkg::SC_4: wave_sel <= dds_pkg::SQUARE;
                  // modulation keys
                  dds_pkg::SC_5: mod_sel <= dds_pkg::ASK;
                  dds_pkg::SC_6: mod_sel <= dds_pkg::BPSK;
                  dds_pkg::SC_7: mod_sel <= dds_pkg::RAW;
                  dds_pkg::SC_8: mod_sel <= dds_pkg::CARRIER;
                  default: ;  // other keys ignored
               endcase
            end
            AFTER_BREAK:
            begin
               // swallow the released key code
               state <= IDLE;
            end
            default:
            begin
               state <= IDLE;
            end
         endcase
      end
   end

endmodule

/* hdl/lfsr_bit_source.sv */
`timescale 1ns/1ns

module lfsr_bit_source
(
   input  logic CLK_25MHZ,
   input  logic reset_from_key,
   output logic symbol_bit
);

   logic [dds_pkg::SYMBOL_CNT_W-1:0] div_cnt;
   logic [dds_pkg::LFSR_W-1:0]       lfsr;
   logic                             sym_tick;

   assign sym_tick = (div_cnt == dds_pkg::SYMBOL_CNT_W'(dds_pkg::SYMBOL_DIV - 1));

   // symbol rate divider
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         div_cnt <= '0;
      else if (sym_tick)
         div_cnt <= '0;
      else
         div_cnt <= div_cnt + 1'b1;
   end

   // taps 5 and 3 give period 31
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         lfsr <= dds_pkg::LFSR_SEED;
      else if (sym_tick)
         lfsr <= {lfsr[3:0], lfsr[4] ^ lfsr[2]};
   end

   assign symbol_bit = lfsr[0];

endmodule

/* hdl/dds_wave_gen.sv */
`timescale 1ns/1ns

module dds_wave_gen
(
   input  logic             CLK_25MHZ,
   input  logic             reset_from_key,
   output dds_pkg::sample_t sin_s,
   output dds_pkg::sample_t cos_s,
   output dds_pkg::sample_t saw_s,
   output dds_pkg::sample_t squ_s
);

   logic [dds_pkg::PHASE_W-1:0]    phase;
   logic [1:0]                     quad;
   logic [1:0]                     cos_quad;
   logic [dds_pkg::LUT_ADDR_W-1:0] addr;

   // full sine from the quarter table
   function automatic dds_pkg::sample_t fold_quarter
   (
      input logic [1:0]                     q,
      input logic [dds_pkg::LUT_ADDR_W-1:0] a
   );
      logic [dds_pkg::LUT_ADDR_W-1:0] idx;
      dds_pkg::sample_t               mag;
      idx = q[0] ? ~a : a;    // mirror odd quadrants
      mag = dds_pkg::sample_t'(dds_pkg::SINE_QUARTER[idx]);
      return q[1] ? -mag : mag;  // lower half negative
   endfunction

   //////////////////////////////////////////////////
   // stage 1: phase accumulator
   //////////////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         phase <= '0;
      else
         phase <= phase + dds_pkg::PHASE_INC;
   end

   assign quad     = phase[dds_pkg::PHASE_W-1 -: 2];
   assign addr     = phase[dds_pkg::PHASE_W-3 -: dds_pkg::LUT_ADDR_W];
   assign cos_quad = quad + 2'd1;  // one quadrant ahead

   //////////////////////////////////////////////////
   // stage 2: table and shape registers
   //////////////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         sin_s <= '0;
         cos_s <= '0;
         saw_s <= '0;
         squ_s <= '0;
      end
      else
      begin
         sin_s <= fold_quarter(quad, addr);
         cos_s <= fold_quarter(cos_quad, addr);
         // offset binary to two's complement
         saw_s <= {~phase[dds_pkg::PHASE_W-1],
                   phase[dds_pkg::PHASE_W-2 -: dds_pkg::SAMPLE_W-1]};
         squ_s <= phase[dds_pkg::PHASE_W-1] ? dds_pkg::SAMPLE_MIN : dds_pkg::SAMPLE_MAX;
      end
   end

endmodule

/* hdl/symbol_modulator.sv */
`timescale 1ns/1ns

module symbol_modulator
(
   input  logic              CLK_25MHZ,
   input  logic              reset_from_key,
   input  dds_pkg::mod_sel_e mod_sel,
   input  dds_pkg::sample_t  cos_s,
   input  logic              symbol_bit,
   output dds_pkg::sample_t  mod_s
);

   dds_pkg::sample_t mod_next;

   always_comb
   begin
      case (mod_sel)
         dds_pkg::ASK:
            mod_next = symbol_bit ? cos_s : '0;      // on-off keying
         dds_pkg::BPSK:
            mod_next = symbol_bit ? cos_s : -cos_s;  // 180 deg flip on zero
         dds_pkg::RAW:
            mod_next = symbol_bit ? dds_pkg::SAMPLE_MAX : dds_pkg::SAMPLE_MIN;
         default:
            mod_next = cos_s;
      endcase
   end

   // one register stage
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         mod_s <= '0;
      else
         mod_s <= mod_next;
   end

endmodule

/* hdl/sample_output.sv */
`timescale 1ns/1ns

module sample_output
(
   input  logic               CLK_25MHZ,
   input  logic               reset_from_key,
   input  dds_pkg::wave_sel_e wave_sel,
   input  dds_pkg::sample_t   sin_s,
   input  dds_pkg::sample_t   cos_s,
   input  dds_pkg::sample_t   saw_s,
   input  dds_pkg::sample_t   squ_s,
   input  dds_pkg::sample_t   mod_s,
   input  logic               symbol_bit,
   output dds_pkg::sample_t   wave_sample,
   output dds_pkg::sample_t   mod_sample,
   output logic               symbol,
   output logic               sample_valid,
   input  logic               sample_ready
);

   logic [dds_pkg::SAMPLE_CNT_W-1:0] smp_cnt;
   logic                             strobe;
   logic                             capture;
   dds_pkg::sample_t                 wave_mux;

   always_comb
   begin
      case (wave_sel)
         dds_pkg::SINE:   wave_mux = sin_s;
         dds_pkg::COSINE: wave_mux = cos_s;
         dds_pkg::SAW:    wave_mux = saw_s;
         default:         wave_mux = squ_s;
      endcase
   end

   //////////////////////////////////////////////////
   // decimation strobe
   //////////////////////////////////////////////////
   assign strobe = (smp_cnt == dds_pkg::SAMPLE_CNT_W'(dds_pkg::SAMPLE_DIV - 1));

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key || strobe)
         smp_cnt <= '0;
      else
         smp_cnt <= smp_cnt + 1'b1;
   end

   // strobe dropped unless empty or draining this cycle
   assign capture = strobe && (!sample_valid || sample_ready);

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         sample_valid <= 1'b0;
      else if (capture)
         sample_valid <= 1'b1;
      else if (sample_ready)
         sample_valid <= 1'b0;  // transfer done
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (capture)
      begin
         wave_sample <= wave_mux;
         mod_sample  <= mod_s;
         symbol      <= symbol_bit;
      end
   end

endmodule

/* hdl/dds_modulator_top.sv */
`timescale 1ns/1ns

module dds_modulator_top
(
   input  logic             CLK_25MHZ,
   input  logic             reset_from_key,
   input  logic             key_valid,
   input  logic [7:0]       key_code,
   output dds_pkg::sample_t wave_sample,
   output dds_pkg::sample_t mod_sample,
   output logic             symbol,
   output logic             sample_valid,
   input  logic             sample_ready
);

   dds_pkg::wave_sel_e wave_sel;
   dds_pkg::mod_sel_e  mod_sel;
   logic               symbol_bit;
   dds_pkg::sample_t   sin_s;
   dds_pkg::sample_t   cos_s;
   dds_pkg::sample_t   saw_s;
   dds_pkg::sample_t   squ_s;
   dds_pkg::sample_t   mod_s;

   //////////////////////////////////////////////////
   // input side
   //////////////////////////////////////////////////
   key_event_tracker i_key_event_tracker (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .key_valid      (key_valid),
      .key_code       (key_code),
      .wave_sel       (wave_sel),
      .mod_sel        (mod_sel)
   );

   //////////////////////////////////////////////////
   // carriers, symbols and modulation
   //////////////////////////////////////////////////
   lfsr_bit_source i_lfsr_bit_source (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .symbol_bit     (symbol_bit)
   );

   dds_wave_gen i_dds_wave_gen (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .sin_s          (sin_s),
      .cos_s          (cos_s),
      .saw_s          (saw_s),
      .squ_s          (squ_s)
   );

   symbol_modulator i_symbol_modulator (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .mod_sel        (mod_sel),
      .cos_s          (cos_s),     // modulated carrier is always cosine
      .symbol_bit     (symbol_bit),
      .mod_s          (mod_s)
   );

   // output side
   sample_output i_sample_output (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .wave_sel       (wave_sel),
      .sin_s          (sin_s),
      .cos_s          (cos_s),
      .saw_s          (saw_s),
      .squ_s          (squ_s),
      .mod_s          (mod_s),
      .symbol_bit     (symbol_bit),
      .wave_sample    (wave_sample),
      .mod_sample     (mod_sample),
      .symbol         (symbol),
      .sample_valid   (sample_valid),
      .sample_ready   (sample_ready)
   );

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen
(
   output logic CLK_25MHZ,
   output logic reset_from_key
);

   initial
   begin
      CLK_25MHZ      = 1'b0;
      reset_from_key = 1'b1;
      repeat (5) @(posedge CLK_25MHZ);
      #2 reset_from_key = 1'b0;  // release off the edge
   end

   always #20 CLK_25MHZ = ~CLK_25MHZ;  // 40 ns period

endmodule

/* tb/tb_dds_modulator.sv */
`timescale 1ns/1ns

module tb_dds_modulator;

   logic CLK_25MHZ, reset_from_key, key_valid, sample_ready, symbol, sample_valid;
   logic [7:0] key_code;
   dds_pkg::sample_t wave_sample, mod_sample;
   int wk_q[$], mk_q[$], cnt_q[$], duty_q[$];
   dds_pkg::sample_t w_q[$], m_q[$], held_w, held_m;
   logic s_q[$], held_s, hold_pend, reset_d, last_sym, sym_seen;
   logic [4:0] lfsr_model;
   int error_count = 0, check_count = 0, cycle = 0, limit = 2000, duty = 100, last_change = 0;

   tb_clock_gen i_tb_clock_gen (.CLK_25MHZ(CLK_25MHZ), .reset_from_key(reset_from_key));

   dds_modulator_top i_dds_modulator_top (
      .CLK_25MHZ(CLK_25MHZ), .reset_from_key(reset_from_key), .key_valid(key_valid),
      .key_code(key_code), .wave_sample(wave_sample), .mod_sample(mod_sample),
      .symbol(symbol), .sample_valid(sample_valid), .sample_ready(sample_ready)
   );

   task automatic check_sample(input string name, input dds_pkg::sample_t exp,
                               input dds_pkg::sample_t act);
      check_count++;
      if (exp !== act)
      begin
         error_count++;
         $display("** Error: %s expected 0x%03h actual 0x%03h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      check_count++;
      if (exp !== act)
      begin
         error_count++;
         $display("** Error: %s expected 0x%0h actual 0x%0h", name, exp, act);
      end
   endtask

   task automatic rule_failed(input string what);
      check_count++;
      error_count++;
      $display("rule broken: %s", what);
   endtask

   function automatic bit is_sine_value(input dds_pkg::sample_t v);
      dds_pkg::sample_t mag;
      for (int i = 0; i < 16; i++)
      begin
         mag = dds_pkg::sample_t'(dds_pkg::SINE_QUARTER[i]);
         if (v == mag || v == -mag)
            return 1'b1;
      end
      return 1'b0;
   endfunction

   function automatic logic [4:0] lfsr_next(input logic [4:0] r);
      return {r[3:0], r[4] ^ r[2]};  // taps 5 and 3
   endfunction

   function automatic logic [7:0] key_to_code(input int k);
      logic [7:0] codes [8] = '{8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E};
      return codes[k-1];
   endfunction

   task automatic send_byte(input logic [7:0] code);
      @(posedge CLK_25MHZ);
      #2 key_valid = 1'b1;
      key_code = code;
      @(posedge CLK_25MHZ);
      #2 key_valid = 1'b0;
   endtask

   task automatic press_key(input int k);  // make code then release pair
      send_byte(key_to_code(k));
      send_byte(8'hF0);
      send_byte(key_to_code(k));
   endtask

   task automatic next_sample(output dds_pkg::sample_t w, output dds_pkg::sample_t m,
                              output logic s);
      while (w_q.size() == 0)
         @(negedge CLK_25MHZ);
      w = w_q.pop_front();
      m = m_q.pop_front();
      s = s_q.pop_front();
   endtask

   // rules of one case on one transferred sample
   task automatic apply_rules(input int ew, input int em, input dds_pkg::sample_t w,
                              input dds_pkg::sample_t m, input logic s,
                              input dds_pkg::sample_t prev_w, input bit first,
                              inout int drops);
      if ((ew == 1 || ew == 2) && !is_sine_value(w))
         rule_failed($sformatf("wave_sample 0x%03h is not a sine value", w));
      if (ew == 4 && w != 12'sh7FF && w != 12'sh800)
         rule_failed($sformatf("wave_sample 0x%03h is not a square level", w));
      if (ew == 3 && !first && w < prev_w && ++drops > 1)
         rule_failed("saw decreased more than once in the case");
      case (em)
         5: if (!s) check_sample("mod_sample", '0, m);
            else if (ew == 2) check_sample("mod_sample", w, m);
         6: if (ew == 2) check_sample("mod_sample", s ? w : dds_pkg::sample_t'(-w), m);
         7: check_sample("mod_sample", s ? 12'sh7FF : 12'sh800, m);
         default: if (ew == 2) check_sample("mod_sample", w, m);
      endcase
      if (em != 7 && !(em == 5 && !s) && !is_sine_value(m))
         rule_failed($sformatf("mod_sample 0x%03h is not a cosine value", m));
   endtask

   //////////////////////////////////////////////////
   // transfer monitor with stall and symbol checks
   //////////////////////////////////////////////////
   always @(posedge CLK_25MHZ)
   begin
      int steps;
      if (reset_d)
         check_bit("sample_valid", 1'b0, sample_valid);
      reset_d = reset_from_key;
      if (!reset_from_key)
      begin
         cycle++;
         if (hold_pend)
         begin
            check_bit("sample_valid", 1'b1, sample_valid);
            check_sample("wave_sample", held_w, wave_sample);
            check_sample("mod_sample", held_m, mod_sample);
            check_bit("symbol", held_s, symbol);
         end
         hold_pend = sample_valid && !sample_ready;
         {held_w, held_m, held_s} = {wave_sample, mod_sample, symbol};
         if (sample_valid && sample_ready)
         begin
            w_q.push_back(wave_sample);
            m_q.push_back(mod_sample);
            s_q.push_back(symbol);
            if (!sym_seen)
               check_bit("symbol", lfsr_model[0], symbol);
            else if (symbol != last_sym)
            begin
               // whole symbol periods since the previous change
               steps = (cycle - last_change + 2048) / 4096;
               if (steps == 0)
                  rule_failed("symbol changed within one symbol period");
               for (int k = 1; k < steps; k++)
               begin
                  lfsr_model = lfsr_next(lfsr_model);
                  if (lfsr_model[0] != last_sym)
                     rule_failed("symbol missed a change of the lfsr sequence");
               end
               lfsr_model = lfsr_next(lfsr_model);
               check_bit("symbol", lfsr_model[0], symbol);
               last_change = cycle;
            end
            sym_seen = 1'b1;
            last_sym = symbol;
         end
         if (cycle >= limit)
         begin
            $display("timeout: no result after %0d cycles", cycle);
            $display("TESTS FAILED");
            $finish;
         end
      end
   end

   // ready at the case duty, one draw per cycle
   initial
   begin
      sample_ready = 1'b0;
      void'($urandom(45935));
      forever
      begin
         @(posedge CLK_25MHZ);
         #2 sample_ready = ($urandom % 100) < duty;
      end
   end

   initial
   begin
      int fd, a, b, c, d, ew, em, drops, errs;
      string line;
      dds_pkg::sample_t w, m, prev_w;
      logic s;
      {key_valid, key_code, hold_pend, sym_seen, reset_d} = '0;
      lfsr_model = 5'd1;
      fd = $fopen("tb/dds_cases.txt", "r");
      if (fd == 0)
      begin
         $display("could not open tb/dds_cases.txt");
         $display("TESTS FAILED");
         $finish;
      end
      else
      begin
         while (!$feof(fd))
         begin
            if ($fgets(line, fd) == 0 || line.len() == 0 || line[0] == "#")
               continue;
            if ($sscanf(line, "%d %d %d %d", a, b, c, d) == 4)
            begin
               wk_q.push_back(a);
               mk_q.push_back(b);
               cnt_q.push_back(c);
               duty_q.push_back(d);
               limit += c * dds_pkg::SAMPLE_DIV * 4;
            end
         end
         $fclose(fd);
         wait (!reset_from_key);
         foreach (wk_q[t])
         begin
            errs  = error_count;
            drops = 0;
            duty  = duty_q[t];
            ew    = (wk_q[t] == 0) ? 1 : wk_q[t];  // reset defaults
            em    = (mk_q[t] == 0) ? 8 : mk_q[t];
            if (wk_q[t] != 0) press_key(wk_q[t]);
            if (mk_q[t] != 0) press_key(mk_q[t]);
            w_q.delete();
            m_q.delete();
            s_q.delete();
            repeat (2) next_sample(w, m, s);  // stale
            for (int i = 2; i < cnt_q[t]; i++)
            begin
               if (wk_q[t] != 0 && i == cnt_q[t] / 2)
               begin
                  send_byte(8'hF0);  // release of a key not pressed
                  send_byte(key_to_code((ew % 4) + 1));
               end
               next_sample(w, m, s);
               apply_rules(ew, em, w, m, s, prev_w, i == 2, drops);
               prev_w = w;
            end
            $display("case %0d: wave key %0d mod key %0d samples %0d errors %0d", t,
                     wk_q[t], mk_q[t], cnt_q[t], error_count - errs);
         end
         $display("cases %0d, checks %0d, errors %0d", wk_q.size(), check_count, error_count);
         if (error_count == 0)
            $display("TESTS PASSED");
         else
            $display("TESTS FAILED");
         $finish;
      end
   end

endmodule

/* tb/dds_cases.txt */
# wave_key mod_key samples ready_duty_pct (decimal)
# keys 1-4 waveform, 5-8 modulation, 0 sends no key
0 0 30 100
4 8 36 60
3 8 40 80
2 8 30 50
2 5 44 70
2 6 44 40
2 7 44 90
1 6 30 30
4 7 36 55
3 5 36 100
2 5 40 25
1 8 30 65

/* vlog.f */
hdl/dds_pkg.sv
hdl/key_event_tracker.sv
hdl/lfsr_bit_source.sv
hdl/dds_wave_gen.sv
hdl/symbol_modulator.sv
hdl/sample_output.sv
hdl/dds_modulator_top.sv
tb/tb_clock_gen.sv
tb/tb_dds_modulator.sv
